// ==== logic/exe_pkg.sv ====
`default_nettype none

package exe_pkg;

  localparam int data_w     = 32;
  localparam int reg_addr_w = 5;
  localparam int div_steps  = 32;
  // wide enough to hold div_steps itself
  localparam int div_cnt_w  = $clog2(div_steps + 1);

  typedef enum logic [5:0] {
    op_add,
    op_addu,
    op_sub,
    op_subu,
    op_slt,
    op_sltu,
    op_and,
    op_or,
    op_xor,
    op_nor,
    op_sll,
    op_srl,
    op_sra,
    op_lui,
    op_lw,
    op_lh,
    op_lhu,
    op_lb,
    op_lbu,
    op_sw,
    op_sh,
    op_sb,
    op_div,
    op_divu,
    op_mthi,
    op_mtlo,
    op_mfhi,
    op_mflo
  } exe_op_t;

  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } mem_size_t;

  // mips cause codes
  typedef enum logic [4:0] {
    exc_none = 5'd0,
    exc_adel = 5'd4,
    exc_ades = 5'd5,
    exc_ov   = 5'd12
  } exc_code_t;

  function automatic logic is_load(exe_op_t op);
    return op inside {op_lw, op_lh, op_lhu, op_lb, op_lbu};
  endfunction

  function automatic logic is_store(exe_op_t op);
    return op inside {op_sw, op_sh, op_sb};
  endfunction

  function automatic logic is_div(exe_op_t op);
    return op inside {op_div, op_divu};
  endfunction

endpackage

`default_nettype wire

// ==== logic/exe_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_alu import exe_pkg::*; (
  input  exe_op_t           op,
  input  logic [data_w-1:0] src1,
  input  logic [data_w-1:0] src2,
  output logic [data_w-1:0] result,
  output logic              overflow
);

  logic [data_w-1:0] sum;
  logic [data_w-1:0] diff;
  logic              sum_ovf;
  logic              diff_ovf;
  logic [4:0]        shamt;

  assign sum  = src1 + src2;
  assign diff = src1 - src2;

  // signed overflow: operand signs vs result sign
  assign sum_ovf  = (src1[data_w-1] == src2[data_w-1]) &&
                    (sum[data_w-1] != src1[data_w-1]);
  assign diff_ovf = (src1[data_w-1] != src2[data_w-1]) &&
                    (diff[data_w-1] != src1[data_w-1]);

  // variable shifts take the amount from rs
  assign shamt = src1[4:0];

  always_comb begin
    case (op)
      op_add, op_addu: result = sum;
      op_sub, op_subu: result = diff;
      op_slt:  result = {{(data_w-1){1'b0}}, $signed(src1) < $signed(src2)};
      op_sltu: result = {{(data_w-1){1'b0}}, src1 < src2};
      op_and:  result = src1 & src2;
      op_or:   result = src1 | src2;
      op_xor:  result = src1 ^ src2;
      op_nor:  result = ~(src1 | src2);
      op_sll:  result = src2 << shamt;
      op_srl:  result = src2 >> shamt;
      op_sra:  result = $unsigned($signed(src2) >>> shamt);
      op_lui:  result = {src2[15:0], 16'h0000};
      // loads, stores and the rest use the address adder
      default: result = sum;
    endcase
  end

  always_comb begin
    case (op)
      op_add:  overflow = sum_ovf;
      op_sub:  overflow = diff_ovf;
      default: overflow = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/store_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_align import exe_pkg::*; (
  input  exe_op_t           op,
  input  logic [1:0]        addr_low,
  input  logic [data_w-1:0] rt,
  output logic [data_w-1:0] wdata,
  output logic [3:0]        wstrb,
  output mem_size_t         size,
  output logic              misaligned
);

  logic mem_op;

  assign mem_op = is_load(op) || is_store(op);

  always_comb begin
    case (op)
      op_lw, op_sw:         size = size_word;
      op_lh, op_lhu, op_sh: size = size_half;
      default:              size = size_byte;
    endcase
  end

  // replicate the low byte/halfword across the word
  always_comb begin
    case (size)
      size_byte: wdata = {4{rt[7:0]}};
      size_half: wdata = {2{rt[15:0]}};
      default:   wdata = rt;
    endcase
  end

  always_comb begin
    if (!is_store(op)) begin
      wstrb = 4'b0000;
    end else begin
      case (size)
        size_byte: wstrb = 4'b0001 << addr_low;
        size_half: wstrb = addr_low[1] ? 4'b1100 : 4'b0011;
        default:   wstrb = 4'b1111;
      endcase
    end
  end

  always_comb begin
    case (size)
      size_word: misaligned = mem_op && (addr_low != 2'b00);
      size_half: misaligned = mem_op && addr_low[0];
      default:   misaligned = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/serial_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module serial_divider import exe_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  logic              is_signed,
  input  logic [data_w-1:0] dividend,
  input  logic [data_w-1:0] divisor,
  output logic              busy,
  output logic              done,
  output logic [data_w-1:0] quotient,
  output logic [data_w-1:0] remainder
);

  logic [div_cnt_w-1:0] count_r;
  logic                 busy_r;
  logic                 done_r;

  logic [data_w-1:0] quot_r;
  logic [data_w-1:0] rem_r;
  logic [data_w-1:0] dvsr_r;
  logic              q_neg_r;
  logic              r_neg_r;

  logic [data_w-1:0] dvnd_abs;
  logic [data_w-1:0] dvsr_abs;
  logic [data_w:0]   rem_shift;
  logic [data_w:0]   trial;

  // magnitudes; abs of the most negative value still fits unsigned
  assign dvnd_abs = (is_signed && dividend[data_w-1]) ? -dividend : dividend;
  assign dvsr_abs = (is_signed && divisor[data_w-1])  ? -divisor  : divisor;

  // one restoring step
  assign rem_shift = {rem_r, quot_r[data_w-1]};
  assign trial     = rem_shift - {1'b0, dvsr_r};

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_r  <= 1'b0;
      done_r  <= 1'b0;
      count_r <= '0;
    end else if (start) begin
      busy_r  <= 1'b1;
      done_r  <= 1'b0;
      count_r <= div_cnt_w'(div_steps);
    end else if (busy_r) begin
      count_r <= count_r - 1'b1;
      if (count_r == div_cnt_w'(1)) begin
        busy_r <= 1'b0;
        done_r <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      quot_r  <= dvnd_abs;
      rem_r   <= '0;
      dvsr_r  <= dvsr_abs;
      q_neg_r <= is_signed && (dividend[data_w-1] ^ divisor[data_w-1]);
      r_neg_r <= is_signed && dividend[data_w-1];
    end else if (busy_r) begin
      if (!trial[data_w]) begin
        rem_r  <= trial[data_w-1:0];
        quot_r <= {quot_r[data_w-2:0], 1'b1};
      end else begin
        rem_r  <= rem_shift[data_w-1:0];
        quot_r <= {quot_r[data_w-2:0], 1'b0};
      end
    end
  end

  assign busy = busy_r;
  assign done = done_r;

  // sign fix-up, remainder follows the dividend
  assign quotient  = q_neg_r ? -quot_r : quot_r;
  assign remainder = r_neg_r ? -rem_r  : rem_r;

endmodule

`default_nettype wire

// ==== logic/hilo_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module hilo_regs import exe_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              write,
  input  exe_op_t           op,
  input  logic [data_w-1:0] rs,
  input  logic [data_w-1:0] quotient,
  input  logic [data_w-1:0] remainder,
  output logic [data_w-1:0] hi,
  output logic [data_w-1:0] lo
);

  logic              hi_we;
  logic              lo_we;
  logic [data_w-1:0] hi_wdata;
  logic [data_w-1:0] lo_wdata;

  assign hi_we = write && (is_div(op) || op == op_mthi);
  assign lo_we = write && (is_div(op) || op == op_mtlo);

  // division writes remainder to hi, quotient to lo
  assign hi_wdata = is_div(op) ? remainder : rs;
  assign lo_wdata = is_div(op) ? quotient  : rs;

  always_ff @(posedge clk) begin
    if (reset) begin
      hi <= '0;
    end else if (hi_we) begin
      hi <= hi_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      lo <= '0;
    end else if (lo_we) begin
      lo <= lo_wdata;
    end
  end

endmodule

`default_nettype wire

// ==== logic/exe_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_stage import exe_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_valid,
  output logic                  allowin,
  input  exe_op_t               in_op,
  input  logic [data_w-1:0]     in_rs,
  input  logic [data_w-1:0]     in_rt,
  input  logic [data_w-1:0]     in_imm,
  input  logic                  in_src2_is_imm,
  input  logic [reg_addr_w-1:0] in_dest,
  output logic                  out_valid,
  input  logic                  next_allowin,
  output exe_op_t               out_op,
  output logic [data_w-1:0]     out_result,
  output logic [reg_addr_w-1:0] out_dest,
  output logic                  out_excp,
  output exc_code_t             out_exc_code,
  output logic [data_w-1:0]     out_badvaddr,
  output logic                  data_req,
  output logic                  data_wr,
  output mem_size_t             data_size,
  output logic [3:0]            data_wstrb,
  output logic [data_w-1:0]     data_addr,
  output logic [data_w-1:0]     data_wdata,
  input  logic                  data_addr_ok,
  input  logic                  data_data_ok
);

  logic                  valid_r;
  exe_op_t               op_r;
  logic [data_w-1:0]     rs_r;
  logic [data_w-1:0]     rt_r;
  logic [data_w-1:0]     imm_r;
  logic                  src2_is_imm_r;
  logic [reg_addr_w-1:0] dest_r;

  logic [data_w-1:0] src2;
  logic [data_w-1:0] alu_result;
  logic              alu_ovf;
  logic [data_w-1:0] st_wdata;
  logic [3:0]        st_wstrb;
  mem_size_t         st_size;
  logic              misaligned;

  logic              ld_op;
  logic              st_op;
  logic              div_op;
  logic              excp;
  logic              ready_go;
  logic              handoff;

  logic              req_pend_r;
  logic              mem_acc_r;
  logic              outstanding_r;
  logic              accept;
  logic              store_ready;

  logic              div_issued_r;
  logic              div_start;
  logic              div_busy;
  logic              div_done;
  logic [data_w-1:0] quotient;
  logic [data_w-1:0] remainder;
  logic [data_w-1:0] hi;
  logic [data_w-1:0] lo;

  // stage register
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_r <= 1'b0;
    end else if (allowin) begin
      valid_r <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && allowin) begin
      op_r          <= in_op;
      rs_r          <= in_rs;
      rt_r          <= in_rt;
      imm_r         <= in_imm;
      src2_is_imm_r <= in_src2_is_imm;
      dest_r        <= in_dest;
    end
  end

  assign src2 = src2_is_imm_r ? imm_r : rt_r;

  exe_alu u_alu (
    .op       (op_r),
    .src1     (rs_r),
    .src2     (src2),
    .result   (alu_result),
    .overflow (alu_ovf)
  );

  store_align u_store_align (
    .op         (op_r),
    .addr_low   (alu_result[1:0]),
    .rt         (rt_r),
    .wdata      (st_wdata),
    .wstrb      (st_wstrb),
    .size       (st_size),
    .misaligned (misaligned)
  );

  assign ld_op  = is_load(op_r);
  assign st_op  = is_store(op_r);
  assign div_op = is_div(op_r);
  assign excp   = alu_ovf || misaligned;

  // memory request, held once raised until addr_ok
  assign data_req = valid_r && (ld_op || st_op) && !misaligned && !mem_acc_r &&
                    !outstanding_r && (next_allowin || req_pend_r);
  assign accept   = data_req && data_addr_ok;

  always_ff @(posedge clk) begin
    if (reset) begin
      req_pend_r    <= 1'b0;
      mem_acc_r     <= 1'b0;
      outstanding_r <= 1'b0;
    end else begin
      req_pend_r <= data_req && !data_addr_ok;
      if (handoff) begin
        mem_acc_r <= 1'b0;
      end else if (accept) begin
        mem_acc_r <= 1'b1;
      end
      if (accept) begin
        outstanding_r <= 1'b1;
      end else if (data_data_ok) begin
        outstanding_r <= 1'b0;
      end
    end
  end

  // store is done on its data_ok, remembered under back-pressure
  assign store_ready = mem_acc_r && (data_data_ok || !outstanding_r);

  assign data_wr    = st_op;
  assign data_size  = st_size;
  assign data_wstrb = (valid_r && !excp) ? st_wstrb : 4'b0000;
  assign data_addr  = alu_result;
  assign data_wdata = st_wdata;

  // divider, one start per instruction
  assign div_start = valid_r && div_op && !div_issued_r && !div_busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      div_issued_r <= 1'b0;
    end else if (handoff) begin
      div_issued_r <= 1'b0;
    end else if (div_start) begin
      div_issued_r <= 1'b1;
    end
  end

  serial_divider u_div (
    .clk       (clk),
    .reset     (reset),
    .start     (div_start),
    .is_signed (op_r == op_div),
    .dividend  (rs_r),
    .divisor   (rt_r),
    .busy      (div_busy),
    .done      (div_done),
    .quotient  (quotient),
    .remainder (remainder)
  );

  hilo_regs u_hilo (
    .clk       (clk),
    .reset     (reset),
    .write     (handoff && !excp),
    .op        (op_r),
    .rs        (rs_r),
    .quotient  (quotient),
    .remainder (remainder),
    .hi        (hi),
    .lo        (lo)
  );

  // exceptions skip any waiting
  always_comb begin
    if (excp) begin
      ready_go = 1'b1;
    end else if (div_op) begin
      ready_go = div_issued_r && div_done;
    end else if (ld_op) begin
      ready_go = accept || mem_acc_r;
    end else if (st_op) begin
      ready_go = store_ready;
    end else begin
      ready_go = 1'b1;
    end
  end

  assign out_valid = valid_r && ready_go;
  assign handoff   = out_valid && next_allowin;
  assign allowin   = !valid_r || handoff;

  always_comb begin
    if (alu_ovf) begin
      out_exc_code = exc_ov;
    end else if (misaligned && ld_op) begin
      out_exc_code = exc_adel;
    end else if (misaligned && st_op) begin
      out_exc_code = exc_ades;
    end else begin
      out_exc_code = exc_none;
    end
  end

  assign out_op       = op_r;
  assign out_dest     = dest_r;
  assign out_excp     = excp;
  assign out_badvaddr = misaligned ? alu_result : '0;
  assign out_result   = (op_r == op_mflo) ? lo :
                        (op_r == op_mfhi) ? hi : alu_result;

endmodule

`default_nettype wire

// ==== test/exe_stage_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_stage_sva import exe_pkg::*; (
  input logic              clk,
  input logic              reset,
  input logic              allowin,
  input logic              out_valid,
  input logic              next_allowin,
  input logic [data_w-1:0] out_result,
  input exc_code_t         out_exc_code,
  input logic              data_req,
  input logic              data_addr_ok,
  input logic [3:0]        data_wstrb,
  input logic              div_start,
  input logic              div_done
);

  reset_state: assert property (@(posedge clk)
    reset |=> allowin && !out_valid && !data_req && (data_wstrb == 4'b0000))
    else $error("stage not idle after reset");

  req_held: assert property (@(posedge clk) disable iff (reset)
    data_req && !data_addr_ok |=> data_req)
    else $error("data_req dropped before data_addr_ok");

  out_stable: assert property (@(posedge clk) disable iff (reset)
    out_valid && !next_allowin |=>
      out_valid && $stable(out_result) && $stable(out_exc_code))
    else $error("outputs changed while stalled");

  div_latency: assert property (@(posedge clk) disable iff (reset)
    div_start |=> !div_done [*div_steps] ##1 div_done)
    else $error("divider done at the wrong cycle");

endmodule

bind exe_stage exe_stage_sva u_sva (
  .clk          (clk),
  .reset        (reset),
  .allowin      (allowin),
  .out_valid    (out_valid),
  .next_allowin (next_allowin),
  .out_result   (out_result),
  .out_exc_code (out_exc_code),
  .data_req     (data_req),
  .data_addr_ok (data_addr_ok),
  .data_wstrb   (data_wstrb),
  .div_start    (div_start),
  .div_done     (div_done)
);

`default_nettype wire

// ==== test/exe_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_stage_tb import exe_pkg::*; ();

  localparam int          n_instr     = 400;
  localparam int          stall_limit = 300;
  localparam int          cycle_limit = 40000;
  localparam logic [31:0] n_ops       = 32'd28;

  // expected view of one instruction
  typedef struct packed {
    exe_op_t                op;
    logic [data_w-1:0]      result;
    logic                   check_result;
    logic [reg_addr_w-1:0]  dest;
    logic                   excp;
    exc_code_t              code;
    logic [data_w-1:0]      badvaddr;
    logic                   mem;
    mem_size_t              size;
    logic [3:0]             wstrb;
    logic [data_w-1:0]      wdata;
  } expect_t;

  logic                  clk;
  logic                  reset;
  logic                  in_valid;
  logic                  allowin;
  exe_op_t               in_op;
  logic [data_w-1:0]     in_rs;
  logic [data_w-1:0]     in_rt;
  logic [data_w-1:0]     in_imm;
  logic                  in_src2_is_imm;
  logic [reg_addr_w-1:0] in_dest;
  logic                  out_valid;
  logic                  next_allowin;
  exe_op_t               out_op;
  logic [data_w-1:0]     out_result;
  logic [reg_addr_w-1:0] out_dest;
  logic                  out_excp;
  exc_code_t             out_exc_code;
  logic [data_w-1:0]     out_badvaddr;
  logic                  data_req;
  logic                  data_wr;
  mem_size_t             data_size;
  logic [3:0]            data_wstrb;
  logic [data_w-1:0]     data_addr;
  logic [data_w-1:0]     data_wdata;
  logic                  data_addr_ok;
  logic                  data_data_ok;

  logic [31:0]       rng_state;
  logic [data_w-1:0] model_hi;
  logic [data_w-1:0] model_lo;
  expect_t           exp_q[$];
  int                errors;
  int                checks;
  int                handoffs;
  int                mem_wait;

  exe_stage DUT (
    .clk            (clk),
    .reset          (reset),
    .in_valid       (in_valid),
    .allowin        (allowin),
    .in_op          (in_op),
    .in_rs          (in_rs),
    .in_rt          (in_rt),
    .in_imm         (in_imm),
    .in_src2_is_imm (in_src2_is_imm),
    .in_dest        (in_dest),
    .out_valid      (out_valid),
    .next_allowin   (next_allowin),
    .out_op         (out_op),
    .out_result     (out_result),
    .out_dest       (out_dest),
    .out_excp       (out_excp),
    .out_exc_code   (out_exc_code),
    .out_badvaddr   (out_badvaddr),
    .data_req       (data_req),
    .data_wr        (data_wr),
    .data_size      (data_size),
    .data_wstrb     (data_wstrb),
    .data_addr      (data_addr),
    .data_wdata     (data_wdata),
    .data_addr_ok   (data_addr_ok),
    .data_data_ok   (data_data_ok)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Fail %s: got %h, expected %h at %0t", name, got, want, $time);
    end
  endtask

  task automatic make_instr();
    exe_op_t     op;
    logic [31:0] r;
    op = exe_op_t'(6'(rand32() % n_ops));
    r = rand32();
    in_rs = rand32();
    in_rt = rand32();
    in_imm = {{16{r[15]}}, r[15:0]};
    in_src2_is_imm = r[16];
    in_dest = r[21:17];
    if (is_load(op) || is_store(op)) begin
      in_src2_is_imm = 1'b1;
      in_rs[1:0] = 2'b00;
      // mostly aligned, now and then a stray offset
      if (r[24:22] != 3'b000) begin
        in_imm[1:0] = 2'b00;
      end
    end
    if (op == op_lui) begin
      in_src2_is_imm = 1'b1;
    end
    if (is_div(op)) begin
      if (r[25]) begin
        in_rt = in_rt >> r[30:26];
      end
      if (in_rt == 32'h0) begin
        in_rt = 32'h1;
      end
      // most negative / -1 has no signed quotient
      if (op == op_div && in_rs == 32'h8000_0000 && in_rt == 32'hffff_ffff) begin
        in_rt = 32'h2;
      end
    end
    in_op = op;
  endtask

  // expected outputs of the instruction on the input side
  task automatic predict(output expect_t e);
    logic [data_w-1:0] s2;
    logic [data_w:0]   wide;
    logic [data_w-1:0] addr;
    logic              mis;
    s2 = in_src2_is_imm ? in_imm : in_rt;
    e = '0;
    e.op = in_op;
    e.dest = in_dest;
    e.check_result = 1'b1;
    mis = 1'b0;
    case (in_op)
      op_add, op_addu: begin
        e.result = in_rs + s2;
        wide = {in_rs[31], in_rs} + {s2[31], s2};
        e.excp = (in_op == op_add) && (wide[32] != wide[31]);
      end
      op_sub, op_subu: begin
        e.result = in_rs - s2;
        wide = {in_rs[31], in_rs} - {s2[31], s2};
        e.excp = (in_op == op_sub) && (wide[32] != wide[31]);
      end
      op_slt:  e.result = {31'b0, $signed(in_rs) < $signed(s2)};
      op_sltu: e.result = {31'b0, in_rs < s2};
      op_and:  e.result = in_rs & s2;
      op_or:   e.result = in_rs | s2;
      op_xor:  e.result = in_rs ^ s2;
      op_nor:  e.result = ~(in_rs | s2);
      op_sll:  e.result = s2 << in_rs[4:0];
      op_srl:  e.result = s2 >> in_rs[4:0];
      op_sra:  e.result = $signed(s2) >>> in_rs[4:0];
      op_lui:  e.result = {s2[15:0], 16'h0000};
      op_div: begin
        model_lo = $signed(in_rs) / $signed(in_rt);
        model_hi = $signed(in_rs) % $signed(in_rt);
        e.check_result = 1'b0;
      end
      op_divu: begin
        model_lo = in_rs / in_rt;
        model_hi = in_rs % in_rt;
        e.check_result = 1'b0;
      end
      op_mthi: begin
        model_hi = in_rs;
        e.check_result = 1'b0;
      end
      op_mtlo: begin
        model_lo = in_rs;
        e.check_result = 1'b0;
      end
      op_mfhi: e.result = model_hi;
      op_mflo: e.result = model_lo;
      default: begin
        addr = in_rs + s2;
        e.result = addr;
        case (in_op)
          op_lw, op_sw: begin
            e.size = size_word;
            mis = (addr[1:0] != 2'b00);
            e.wdata = in_rt;
            e.wstrb = 4'b1111;
          end
          op_lh, op_lhu, op_sh: begin
            e.size = size_half;
            mis = addr[0];
            e.wdata = {2{in_rt[15:0]}};
            e.wstrb = addr[1] ? 4'b1100 : 4'b0011;
          end
          default: begin
            e.size = size_byte;
            e.wdata = {4{in_rt[7:0]}};
            e.wstrb = 4'b0001 << addr[1:0];
          end
        endcase
        if (is_load(in_op)) begin
          e.wstrb = 4'b0000;
        end
        e.mem = !mis;
        e.excp = mis;
        e.badvaddr = mis ? addr : 32'h0;
        if (mis) begin
          e.code = is_load(in_op) ? exc_adel : exc_ades;
        end
      end
    endcase
    if (e.excp && e.code == exc_none) begin
      e.code = exc_ov;
    end
  endtask

  task automatic finish_run(input logic timed_out);
    $display("checks %0d, handoffs %0d, errors %0d", checks, handoffs, errors);
    if (errors == 0 && !timed_out) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  initial begin
    expect_t               e;
    logic [31:0]           r;
    int                    cycle;
    int                    stall;
    int                    issued;
    logic                  taken;
    logic                  held;
    logic                  req_waiting;
    logic                  timed_out;
    logic                  run_done;
    exe_op_t               saved_op;
    logic [data_w-1:0]     saved_result;
    logic [reg_addr_w-1:0] saved_dest;
    logic                  saved_excp;
    exc_code_t             saved_code;
    logic [data_w-1:0]     saved_badvaddr;

    rng_state = 32'h76c3;
    clk = 1'b0;
    reset = 1'b1;
    in_valid = 1'b0;
    in_op = op_add;
    in_rs = '0;
    in_rt = '0;
    in_imm = '0;
    in_src2_is_imm = 1'b0;
    in_dest = '0;
    next_allowin = 1'b0;
    data_addr_ok = 1'b0;
    data_data_ok = 1'b0;
    model_hi = '0;
    model_lo = '0;
    errors = 0;
    checks = 0;
    handoffs = 0;
    mem_wait = -1;
    cycle = 0;
    stall = 0;
    issued = 0;
    taken = 1'b0;
    held = 1'b0;
    req_waiting = 1'b0;
    timed_out = 1'b0;
    run_done = 1'b0;
    saved_op = op_add;
    saved_result = '0;
    saved_dest = '0;
    saved_excp = 1'b0;
    saved_code = exc_none;
    saved_badvaddr = '0;

    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    while (!run_done) begin
      @(negedge clk);
      cycle++;
      r = rand32();
      next_allowin = (r[1:0] != 2'b00);
      data_addr_ok = (r[3:2] != 2'b00);
      // memory responder, one data_ok per accepted request
      data_data_ok = 1'b0;
      if (mem_wait == 0) begin
        data_data_ok = 1'b1;
        mem_wait = -1;
      end else if (mem_wait > 0) begin
        mem_wait--;
      end
      if (taken) begin
        in_valid = 1'b0;
        taken = 1'b0;
      end
      if (!in_valid && issued < n_instr && r[5:4] != 2'b00) begin
        make_instr();
        in_valid = 1'b1;
        issued++;
      end

      #2;
      if (data_req && (exp_q.size() == 0 || !exp_q[0].mem)) begin
        errors++;
        $display("memory request raised without an aligned load or store at %0t", $time);
      end
      // a stalled next stage only sees a request that was already waiting
      if (data_req && !next_allowin && !req_waiting) begin
        errors++;
        $display("new memory request raised while the next stage stalls at %0t", $time);
      end
      req_waiting = data_req && !data_addr_ok;
      if (exp_q.size() != 0 && exp_q[0].excp) begin
        check_value("data_wstrb", 32'(data_wstrb), 32'h0);
      end
      if (data_req && data_addr_ok) begin
        if (exp_q.size() != 0) begin
          check_value("data_addr", data_addr, exp_q[0].result);
          check_value("data_size", 32'(data_size), 32'(exp_q[0].size));
          check_value("data_wr", 32'(data_wr), 32'(is_store(exp_q[0].op)));
          check_value("data_wstrb", 32'(data_wstrb), 32'(exp_q[0].wstrb));
          if (is_store(exp_q[0].op)) begin
            check_value("data_wdata", data_wdata, exp_q[0].wdata);
          end
        end
        mem_wait = int'(rand32() % 4);
      end

      // outputs must hold while the next stage stalls
      if (held) begin
        check_value("out_valid", 32'(out_valid), 32'h1);
        check_value("out_op", 32'(out_op), 32'(saved_op));
        check_value("out_result", out_result, saved_result);
        check_value("out_dest", 32'(out_dest), 32'(saved_dest));
        check_value("out_excp", 32'(out_excp), 32'(saved_excp));
        check_value("out_exc_code", 32'(out_exc_code), 32'(saved_code));
        check_value("out_badvaddr", out_badvaddr, saved_badvaddr);
      end
      held = out_valid && !next_allowin;
      saved_op = out_op;
      saved_result = out_result;
      saved_dest = out_dest;
      saved_excp = out_excp;
      saved_code = out_exc_code;
      saved_badvaddr = out_badvaddr;

      stall++;
      if (out_valid && next_allowin) begin
        stall = 0;
        if (exp_q.size() == 0) begin
          errors++;
          $display("handoff with no instruction in the stage at %0t", $time);
        end else begin
          e = exp_q.pop_front();
          handoffs++;
          check_value("out_op", 32'(out_op), 32'(e.op));
          check_value("out_dest", 32'(out_dest), 32'(e.dest));
          check_value("out_excp", 32'(out_excp), 32'(e.excp));
          check_value("out_exc_code", 32'(out_exc_code), 32'(e.code));
          check_value("out_badvaddr", out_badvaddr, e.badvaddr);
          if (e.check_result) begin
            check_value("out_result", out_result, e.result);
          end
        end
      end
      if (in_valid && allowin) begin
        stall = 0;
        predict(e);
        exp_q.push_back(e);
        taken = 1'b1;
      end

      if (!in_valid && issued == n_instr && exp_q.size() == 0) begin
        run_done = 1'b1;
      end else if (stall > stall_limit || cycle > cycle_limit) begin
        errors++;
        $display("timeout: the stage made no progress for %0d cycles", stall);
        timed_out = 1'b1;
        run_done = 1'b1;
      end
    end

    if (handoffs != n_instr) begin
      errors++;
      $display("%0d instructions sent but %0d handed off", n_instr, handoffs);
    end
    finish_run(timed_out);
  end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/exe_pkg.sv
logic/exe_alu.sv
logic/store_align.sv
logic/serial_divider.sv
logic/hilo_regs.sv
logic/exe_stage.sv
test/exe_stage_sva.sv
test/exe_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= exe_stage_tb
BUILD_DIR ?= build
LOG       ?= sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert
PASS_LINE ?= NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP BUILD_DIR LOG FILELIST VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o sim -f $(FILELIST)
	./$(BUILD_DIR)/sim > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_LINE)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
